/* design/timer_pkg.sv */
`default_nettype none

package timer_pkg;

    ////////////////////
    // Widths
    ////////////////////
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] div_t;
    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;

    // Count rate, as held in TAC[1:0]
    typedef enum logic [1:0] {
        TAP_1024 = 2'd0,
        TAP_16   = 2'd1,
        TAP_64   = 2'd2,
        TAP_256  = 2'd3
    } tap_sel_e;

    // One divider bit per rate, indexed by tap_sel_e
    typedef logic [3:0] taps_t;

    typedef struct packed {
        logic  wr_tima;
        logic  wr_tma;
        logic  wr_tac;
        byte_t data;
    } chan_wr_t;

    typedef struct packed {
        byte_t tima;
        byte_t tma;
        byte_t tac;
    } chan_regs_t;

    ////////////////////
    // Register map
    ////////////////////
    localparam addr_t ADDR_DIV       = 8'h00;
    localparam addr_t ADDR_IF        = 8'h04;
    localparam addr_t ADDR_IE        = 8'h08;
    localparam addr_t ADDR_CHAN_BASE = 8'h10;
    localparam addr_t CHAN_STRIDE    = 8'h10;

    // Offsets inside one channel window
    localparam addr_t OFS_TIMA = 8'h0;
    localparam addr_t OFS_TMA  = 8'h4;
    localparam addr_t OFS_TAC  = 8'h8;

    localparam int TAC_EN_BIT = 2;

    localparam data_t      UNMAPPED_DATA = 32'h0000_00FF;
    localparam logic [1:0] RESP_OKAY     = 2'b00;

endpackage

`default_nettype wire

/* design/div_prescaler.sv */
`timescale 1ns/1ps
`default_nettype none

module div_prescaler (
    input  logic             clk,
    input  logic             rst,
    input  logic             div_clear,
    output timer_pkg::div_t  div_count,
    output timer_pkg::taps_t taps
);

    // Divider bit behind each count rate
    localparam int BIT_1024 = 9;
    localparam int BIT_16   = 3;
    localparam int BIT_64   = 5;
    localparam int BIT_256  = 7;

    timer_pkg::div_t count_q;

    // Free running, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
        end else if (div_clear) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 16'd1;
        end
    end

    assign div_count = count_q;

    // Tap vector in enum order
    assign taps[timer_pkg::TAP_1024] = count_q[BIT_1024];
    assign taps[timer_pkg::TAP_16]   = count_q[BIT_16];
    assign taps[timer_pkg::TAP_64]   = count_q[BIT_64];
    assign taps[timer_pkg::TAP_256]  = count_q[BIT_256];

endmodule

`default_nettype wire

/* design/timer_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_channel (
    input  logic                  clk,
    input  logic                  rst,
    input  timer_pkg::taps_t      taps,
    input  timer_pkg::chan_wr_t   wr,
    output timer_pkg::chan_regs_t regs,
    output logic                  overflow
);

    timer_pkg::byte_t    tima_q;
    timer_pkg::byte_t    tma_q;
    timer_pkg::byte_t    tac_q;
    timer_pkg::tap_sel_e tap_sel;

    logic tap_gated;
    logic tap_prev;
    logic tick;
    logic carry_q;
    logic overflow_q;

    ////////////////////
    // Tap selection
    ////////////////////
    assign tap_sel   = timer_pkg::tap_sel_e'(tac_q[1:0]);
    assign tap_gated = tac_q[timer_pkg::TAC_EN_BIT] & taps[tap_sel];

    // Rising edge of the gated tap, one cycle late through tap_prev
    assign tick = tap_gated & ~tap_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            tap_prev <= 1'b0;
        end else begin
            tap_prev <= tap_gated;
        end
    end

    ////////////////////
    // TMA and TAC
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            tma_q <= '0;
            tac_q <= '0;
        end else begin
            if (wr.wr_tma) begin
                tma_q <= wr.data;
            end
            if (wr.wr_tac) begin
                tac_q <= wr.data;
            end
        end
    end

    ////////////////////
    // Counter
    ////////////////////
    // After a wrap TIMA sits at zero for one cycle, then reloads
    always_ff @(posedge clk) begin
        if (rst) begin
            tima_q     <= '0;
            carry_q    <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            overflow_q <= 1'b0;
            if (wr.wr_tima) begin
                // Bus write wins and cancels a pending reload
                tima_q  <= wr.data;
                carry_q <= 1'b0;
            end else if (carry_q) begin
                tima_q     <= tma_q;
                carry_q    <= 1'b0;
                overflow_q <= 1'b1;
            end else if (tick) begin
                {carry_q, tima_q} <= {1'b0, tima_q} + 9'd1;
            end
        end
    end

    assign overflow = overflow_q;

    assign regs.tima = tima_q;
    assign regs.tma  = tma_q;
    assign regs.tac  = tac_q;

endmodule

`default_nettype wire

/* design/timer_irq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_irq_ctrl #(
    parameter int N_CHANNELS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [N_CHANNELS-1:0] overflow,
    input  timer_pkg::byte_t      if_clear_mask,
    input  logic                  ie_wr,
    input  timer_pkg::byte_t      ie_data,
    output timer_pkg::byte_t      if_reg,
    output timer_pkg::byte_t      ie_reg,
    output logic                  irq
);

    logic [N_CHANNELS-1:0] pending_q;
    logic [N_CHANNELS-1:0] enable_q;
    logic                  irq_q;

    // Sticky pending bits, a new overflow beats a clear
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~if_clear_mask[N_CHANNELS-1:0]) | overflow;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q <= '0;
        end else if (ie_wr) begin
            enable_q <= ie_data[N_CHANNELS-1:0];
        end
    end

    // Level interrupt, registered
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(pending_q & enable_q);
        end
    end

    // Unused upper bits read as zero
    assign if_reg = timer_pkg::byte_t'(pending_q);
    assign ie_reg = timer_pkg::byte_t'(enable_q);
    assign irq    = irq_q;

endmodule

`default_nettype wire

/* design/timer_axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_axil_regs #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  timer_pkg::addr_t                       awaddr,
    input  logic                                   awvalid,
    output logic                                   awready,
    input  timer_pkg::data_t                       wdata,
    input  logic [3:0]                             wstrb,
    input  logic                                   wvalid,
    output logic                                   wready,
    output logic [1:0]                             bresp,
    output logic                                   bvalid,
    input  logic                                   bready,
    input  timer_pkg::addr_t                       araddr,
    input  logic                                   arvalid,
    output logic                                   arready,
    output timer_pkg::data_t                       rdata,
    output logic [1:0]                             rresp,
    output logic                                   rvalid,
    input  logic                                   rready,
    input  timer_pkg::div_t                        div_count,
    input  timer_pkg::chan_regs_t [N_CHANNELS-1:0] chan_regs,
    input  timer_pkg::byte_t                       if_reg,
    input  timer_pkg::byte_t                       ie_reg,
    output logic                                   div_clear,
    output timer_pkg::chan_wr_t [N_CHANNELS-1:0]   chan_wr,
    output timer_pkg::byte_t                       if_clear_mask,
    output logic                                   ie_wr,
    output timer_pkg::byte_t                       ie_data
);

    typedef enum logic {
        IDLE,
        RESP
    } hs_state_e;

    hs_state_e        w_state;
    hs_state_e        r_state;
    logic             wr_accept;
    logic             wr_en;
    logic             rd_accept;
    timer_pkg::byte_t wr_byte;
    timer_pkg::data_t rd_mux;

    // Byte address of one register inside channel idx
    function automatic timer_pkg::addr_t chan_addr(input int idx, input timer_pkg::addr_t ofs);
        chan_addr = timer_pkg::addr_t'(timer_pkg::ADDR_CHAN_BASE
                                       + timer_pkg::CHAN_STRIDE * idx + ofs);
    endfunction

    ////////////////////
    // Write channel
    ////////////////////
    assign wr_accept = (w_state == IDLE) && awvalid && wvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign bvalid    = (w_state == RESP);
    assign bresp     = timer_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            w_state <= IDLE;
        end else begin
            case (w_state)
                IDLE: if (wr_accept) w_state <= RESP;
                RESP: if (bready) w_state <= IDLE;
                default: w_state <= IDLE;
            endcase
        end
    end

    // Strobes fire on the acceptance edge, lane 0 only
    assign wr_en     = wr_accept && wstrb[0];
    assign wr_byte   = wdata[7:0];
    assign div_clear = wr_en && (awaddr == timer_pkg::ADDR_DIV);
    assign ie_wr     = wr_en && (awaddr == timer_pkg::ADDR_IE);
    assign ie_data   = wr_byte;
    assign if_clear_mask = (wr_en && (awaddr == timer_pkg::ADDR_IF)) ? wr_byte : '0;

    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan_wr
        assign chan_wr[i].wr_tima = wr_en && (awaddr == chan_addr(i, timer_pkg::OFS_TIMA));
        assign chan_wr[i].wr_tma  = wr_en && (awaddr == chan_addr(i, timer_pkg::OFS_TMA));
        assign chan_wr[i].wr_tac  = wr_en && (awaddr == chan_addr(i, timer_pkg::OFS_TAC));
        assign chan_wr[i].data    = wr_byte;
    end

    ////////////////////
    // Read channel
    ////////////////////
    assign rd_accept = (r_state == IDLE) && arvalid;
    assign arready   = rd_accept;
    assign rvalid    = (r_state == RESP);
    assign rresp     = timer_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_state <= IDLE;
        end else begin
            case (r_state)
                IDLE: if (rd_accept) r_state <= RESP;
                RESP: if (rready) r_state <= IDLE;
                default: r_state <= IDLE;
            endcase
        end
    end

    // Addressed byte, zero extended
    always_comb begin
        rd_mux = timer_pkg::UNMAPPED_DATA;
        if (araddr == timer_pkg::ADDR_DIV) begin
            rd_mux = timer_pkg::data_t'(div_count[15:8]);
        end else if (araddr == timer_pkg::ADDR_IF) begin
            rd_mux = timer_pkg::data_t'(if_reg);
        end else if (araddr == timer_pkg::ADDR_IE) begin
            rd_mux = timer_pkg::data_t'(ie_reg);
        end
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (araddr == chan_addr(i, timer_pkg::OFS_TIMA)) begin
                rd_mux = timer_pkg::data_t'(chan_regs[i].tima);
            end else if (araddr == chan_addr(i, timer_pkg::OFS_TMA)) begin
                rd_mux = timer_pkg::data_t'(chan_regs[i].tma);
            end else if (araddr == chan_addr(i, timer_pkg::OFS_TAC)) begin
                rd_mux = timer_pkg::data_t'(chan_regs[i].tac);
            end
        end
    end

    // Held until rready
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (rd_accept) begin
            rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* design/timer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_top #(
    parameter int N_CHANNELS = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  timer_pkg::addr_t awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  timer_pkg::data_t wdata,
    input  logic [3:0]       wstrb,
    input  logic             wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  logic             bready,
    input  timer_pkg::addr_t araddr,
    input  logic             arvalid,
    output logic             arready,
    output timer_pkg::data_t rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  logic             rready,
    output logic             irq
);

    logic                                   div_clear;
    timer_pkg::div_t                        div_count;
    timer_pkg::taps_t                       taps;
    timer_pkg::chan_wr_t [N_CHANNELS-1:0]   chan_wr;
    timer_pkg::chan_regs_t [N_CHANNELS-1:0] chan_regs;
    logic [N_CHANNELS-1:0]                  overflow;
    timer_pkg::byte_t                       if_clear_mask;
    logic                                   ie_wr;
    timer_pkg::byte_t                       ie_data;
    timer_pkg::byte_t                       if_reg;
    timer_pkg::byte_t                       ie_reg;

    // Bus front end
    timer_axil_regs #(
        .N_CHANNELS(N_CHANNELS)
    ) i_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .div_count(div_count), .chan_regs(chan_regs),
        .if_reg(if_reg), .ie_reg(ie_reg),
        .div_clear(div_clear), .chan_wr(chan_wr),
        .if_clear_mask(if_clear_mask), .ie_wr(ie_wr), .ie_data(ie_data)
    );

    div_prescaler i_div (
        .clk(clk), .rst(rst),
        .div_clear(div_clear),
        .div_count(div_count),
        .taps(taps)
    );

    ////////////////////
    // Channels
    ////////////////////
    for (genvar i = 0; i < N_CHANNELS; i++) begin : g_chan
        timer_channel i_chan (
            .clk(clk), .rst(rst),
            .taps(taps),
            .wr(chan_wr[i]),
            .regs(chan_regs[i]),
            .overflow(overflow[i])
        );
    end

    timer_irq_ctrl #(
        .N_CHANNELS(N_CHANNELS)
    ) i_irq (
        .clk(clk), .rst(rst),
        .overflow(overflow),
        .if_clear_mask(if_clear_mask),
        .ie_wr(ie_wr), .ie_data(ie_data),
        .if_reg(if_reg), .ie_reg(ie_reg),
        .irq(irq)
    );

endmodule

`default_nettype wire

/* dv/timer_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_properties (
    input logic             clk,
    input logic             rst,
    input logic             awready,
    input logic             wready,
    input logic             bvalid,
    input logic             bready,
    input logic             arready,
    input logic             rvalid,
    input logic             rready,
    input timer_pkg::data_t rdata,
    input timer_pkg::byte_t if_reg,
    input timer_pkg::byte_t ie_reg,
    input logic             irq
);

    // Write response waits for the master
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // Read data frozen until taken
    a_rdata_stable: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rdata or rvalid changed while waiting for rready");

    // irq is registered from the masked pending byte
    a_irq_cause: assert property (@(posedge clk) disable iff (rst)
        irq |-> $past(if_reg & ie_reg) != 8'h00)
        else $error("irq high with no enabled pending bit");

    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !(awready || wready || bvalid || arready || rvalid || irq))
        else $error("handshake output high right after reset");

endmodule

bind timer_top timer_properties i_props (
    .clk(clk), .rst(rst),
    .awready(awready), .wready(wready),
    .bvalid(bvalid), .bready(bready),
    .arready(arready), .rvalid(rvalid), .rready(rready),
    .rdata(rdata), .if_reg(if_reg), .ie_reg(ie_reg), .irq(irq)
);

`default_nettype wire

/* dv/timer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_tb;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_RD_TOL,
        OP_POLL,
        OP_WAIT_IRQ,
        OP_IRQ_LOW
    } op_e;

    typedef struct packed {
        op_e              op;
        timer_pkg::addr_t addr;
        timer_pkg::byte_t data;
        timer_pkg::byte_t want;
    } step_t;

    logic             clk;
    logic             rst;
    timer_pkg::addr_t awaddr;
    logic             awvalid;
    logic             awready;
    timer_pkg::data_t wdata;
    logic [3:0]       wstrb;
    logic             wvalid;
    logic             wready;
    logic [1:0]       bresp;
    logic             bvalid;
    logic             bready;
    timer_pkg::addr_t araddr;
    logic             arvalid;
    logic             arready;
    timer_pkg::data_t rdata;
    logic [1:0]       rresp;
    logic             rvalid;
    logic             rready;
    logic             irq;

    step_t            steps[$];
    integer           seed;
    int               cycle_count = 0;
    int               cycle_limit = 20000;
    int               order[4];
    timer_pkg::byte_t tma_val[4];

    timer_top #(
        .N_CHANNELS(4)
    ) i_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Run limit, sized from the stimulus table
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout: test did not finish");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic timer_pkg::addr_t reg_addr(input int ch, input timer_pkg::addr_t ofs);
        reg_addr = timer_pkg::addr_t'(16 * ch) + timer_pkg::ADDR_CHAN_BASE + ofs;
    endfunction

    function automatic timer_pkg::byte_t chan_bit(input int ch);
        chan_bit = timer_pkg::byte_t'(1 << ch);
    endfunction

    // TAC value with enable set and the given rate
    function automatic timer_pkg::byte_t run_tac(input timer_pkg::tap_sel_e sel);
        run_tac = timer_pkg::byte_t'((1 << timer_pkg::TAC_EN_BIT) | int'(sel));
    endfunction

    task automatic check(input string name, input timer_pkg::data_t got,
                         input timer_pkg::data_t want);
        if (got !== want) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, want);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic axil_write(input timer_pkg::addr_t addr, input timer_pkg::byte_t data);
        awaddr  = addr;
        wdata   = timer_pkg::data_t'(data);
        wstrb   = 4'b0001;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        // Address and data are taken together
        @(posedge clk);
        while (!awready) @(posedge clk);
        check("wready", timer_pkg::data_t'(wready), 32'h1);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check("bvalid", timer_pkg::data_t'(bvalid), 32'h1);
        check("bresp", timer_pkg::data_t'(bresp), '0);
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input timer_pkg::addr_t addr, output timer_pkg::data_t data);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        check("rvalid", timer_pkg::data_t'(rvalid), 32'h1);
        check("rresp", timer_pkg::data_t'(rresp), '0);
        data   = rdata;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////
    task automatic push_step(input op_e op, input timer_pkg::addr_t addr,
                             input timer_pkg::byte_t data, input timer_pkg::byte_t want);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.want = want;
        steps.push_back(s);
    endtask

    task automatic add_write(input timer_pkg::addr_t addr, input timer_pkg::byte_t data);
        push_step(OP_WR, addr, data, '0);
    endtask

    task automatic add_read(input timer_pkg::addr_t addr, input timer_pkg::byte_t want);
        push_step(OP_RD, addr, '0, want);
    endtask

    task automatic build_steps();
        int n;
        int m;
        int a;
        int b;
        int j;
        int tmp;
        for (int i = 0; i < 4; i++) begin
            order[i]   = i;
            tma_val[i] = timer_pkg::byte_t'($random(seed) & 32'h7f);
        end
        // Shuffle the channel order
        for (int i = 3; i > 0; i--) begin
            j = int'($unsigned($random(seed)) % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        n = order[0];
        m = order[1];
        a = order[2];
        b = order[3];

        push_step(OP_IRQ_LOW, '0, '0, '0);
        add_read(timer_pkg::ADDR_IF, 8'h00);
        add_read(timer_pkg::ADDR_IE, 8'h00);

        // Readback with enable clear
        for (int ch = 0; ch < 4; ch++) begin
            add_write(reg_addr(ch, timer_pkg::OFS_TMA), tma_val[ch]);
            add_write(reg_addr(ch, timer_pkg::OFS_TAC), timer_pkg::byte_t'(8 + ch));
            add_write(reg_addr(ch, timer_pkg::OFS_TIMA), timer_pkg::byte_t'(8'hA0 + ch));
        end
        for (int ch = 0; ch < 4; ch++) begin
            add_read(reg_addr(ch, timer_pkg::OFS_TMA), tma_val[ch]);
            add_read(reg_addr(ch, timer_pkg::OFS_TAC), timer_pkg::byte_t'(8 + ch));
            add_read(reg_addr(ch, timer_pkg::OFS_TIMA), timer_pkg::byte_t'(8'hA0 + ch));
        end
        add_read(8'h0C, 8'hFF);
        add_read(8'h1C, 8'hFF);
        add_read(8'h50, 8'hFF);

        // Let DIV climb off zero before clearing it
        push_step(OP_POLL, timer_pkg::ADDR_DIV, '0, 8'h02);
        add_write(timer_pkg::ADDR_DIV, 8'h5A);
        add_read(timer_pkg::ADDR_DIV, 8'h00);

        // Overflow and reload
        add_write(reg_addr(n, timer_pkg::OFS_TMA), tma_val[n]);
        add_write(reg_addr(n, timer_pkg::OFS_TIMA), 8'hFF);
        add_write(timer_pkg::ADDR_IE, chan_bit(n));
        add_write(reg_addr(n, timer_pkg::OFS_TAC), run_tac(timer_pkg::TAP_16));
        push_step(OP_WAIT_IRQ, '0, '0, '0);
        add_read(timer_pkg::ADDR_IF, chan_bit(n));
        add_write(reg_addr(n, timer_pkg::OFS_TAC), 8'h00);
        push_step(OP_RD_TOL, reg_addr(n, timer_pkg::OFS_TIMA), '0, tma_val[n]);

        // Masked overflow
        add_write(timer_pkg::ADDR_IE, 8'h00);
        push_step(OP_IRQ_LOW, '0, '0, '0);
        add_write(reg_addr(m, timer_pkg::OFS_TMA), tma_val[m]);
        add_write(reg_addr(m, timer_pkg::OFS_TIMA), 8'hFF);
        add_write(reg_addr(m, timer_pkg::OFS_TAC), run_tac(timer_pkg::TAP_16));
        push_step(OP_POLL, timer_pkg::ADDR_IF, '0, chan_bit(n) | chan_bit(m));
        push_step(OP_IRQ_LOW, '0, '0, '0);
        add_write(reg_addr(m, timer_pkg::OFS_TAC), 8'h00);
        add_write(timer_pkg::ADDR_IE, chan_bit(m));
        push_step(OP_WAIT_IRQ, '0, '0, '0);

        // Write-1-to-clear
        add_write(timer_pkg::ADDR_IF, chan_bit(m));
        push_step(OP_IRQ_LOW, '0, '0, '0);
        add_read(timer_pkg::ADDR_IF, chan_bit(n));
        add_write(timer_pkg::ADDR_IF, chan_bit(n));
        add_read(timer_pkg::ADDR_IF, 8'h00);

        // Slow channels must not flag while the fast one overflows
        add_write(timer_pkg::ADDR_IE, chan_bit(a));
        add_write(reg_addr(n, timer_pkg::OFS_TIMA), 8'h00);
        add_write(reg_addr(n, timer_pkg::OFS_TAC), run_tac(timer_pkg::TAP_64));
        add_write(reg_addr(m, timer_pkg::OFS_TIMA), 8'h00);
        add_write(reg_addr(m, timer_pkg::OFS_TAC), run_tac(timer_pkg::TAP_256));
        add_write(reg_addr(b, timer_pkg::OFS_TIMA), 8'h00);
        add_write(reg_addr(b, timer_pkg::OFS_TAC), run_tac(timer_pkg::TAP_1024));
        add_write(reg_addr(a, timer_pkg::OFS_TMA), tma_val[a]);
        add_write(reg_addr(a, timer_pkg::OFS_TIMA), 8'hFF);
        add_write(reg_addr(a, timer_pkg::OFS_TAC), run_tac(timer_pkg::TAP_16));
        push_step(OP_WAIT_IRQ, '0, '0, '0);
        add_read(timer_pkg::ADDR_IF, chan_bit(a));
        add_write(reg_addr(a, timer_pkg::OFS_TAC), 8'h00);
        push_step(OP_RD_TOL, reg_addr(a, timer_pkg::OFS_TIMA), '0, tma_val[a]);
        add_write(reg_addr(n, timer_pkg::OFS_TAC), 8'h00);
        add_write(reg_addr(m, timer_pkg::OFS_TAC), 8'h00);
        add_write(reg_addr(b, timer_pkg::OFS_TAC), 8'h00);
    endtask

    task automatic run_step(input step_t s);
        timer_pkg::data_t got;
        timer_pkg::data_t want;
        case (s.op)
            OP_WR: axil_write(s.addr, s.data);
            OP_RD, OP_RD_TOL: begin
                axil_read(s.addr, got);
                want = timer_pkg::data_t'(s.want);
                // One extra TAP_16 tick may land before the stop write
                if (s.op == OP_RD_TOL && got == {24'h0, s.want + 8'd1}) begin
                    want = got;
                end
                check($sformatf("rdata @0x%02h", s.addr), got, want);
            end
            OP_POLL: begin
                axil_read(s.addr, got);
                while (got != timer_pkg::data_t'(s.want)) begin
                    axil_read(s.addr, got);
                end
            end
            OP_WAIT_IRQ: begin
                while (!irq) @(negedge clk);
            end
            OP_IRQ_LOW: check("irq", timer_pkg::data_t'(irq), '0);
            default: ;
        endcase
    endtask

    initial begin
        seed    = 32'hab7b;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        build_steps();
        cycle_limit = steps.size() * 300 + 20000;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
design/timer_pkg.sv
design/div_prescaler.sv
design/timer_channel.sv
design/timer_irq_ctrl.sv
design/timer_axil_regs.sv
design/timer_top.sv
dv/timer_properties.sv
dv/timer_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= timer_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
